/* aes_dec.f */
+incdir+.
aes_pkg.sv
aes_round_if.sv
aes_sbox.sv
aes_inv_round.sv
aes_key_sched.sv
aes_dec_iter.sv
aes_dec.sv
tb_aes_dec.sv

/* run_sim.sh */
#!/bin/sh
# Build the AES-128 decryption testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
	--top-module tb_aes_dec -f aes_dec.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_aes_dec
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

/* tb_aes_vectors.svh */
`ifndef TB_AES_VECTORS_SVH
`define TB_AES_VECTORS_SVH

// known-answer vectors as key, ciphertext, plaintext

// FIPS-197 appendix C.1
localparam aes_pkg::state_t key_fips_c1 = 128'h000102030405060708090a0b0c0d0e0f;
localparam aes_pkg::state_t ct_fips_c1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam aes_pkg::state_t pt_fips_c1 = 128'h00112233445566778899aabbccddeeff;

// FIPS-197 appendix B
localparam aes_pkg::state_t key_fips_b = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam aes_pkg::state_t ct_fips_b = 128'h3925841d02dc09fbdc118597196a0b32;
localparam aes_pkg::state_t pt_fips_b = 128'h3243f6a8885a308d313198a2e0370734;

// ECB-AES128 blocks of NIST SP 800-38A, same key as appendix B
localparam aes_pkg::state_t ct_ecb_1 = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
localparam aes_pkg::state_t pt_ecb_1 = 128'h6bc1bee22e409f96e93d7e117393172a;

localparam aes_pkg::state_t ct_ecb_2 = 128'hf5d3d58503b9699de785895a96fdbaaf;
localparam aes_pkg::state_t pt_ecb_2 = 128'hae2d8a571e03ac9c9eb76fac45af8e51;

localparam aes_pkg::state_t ct_ecb_3 = 128'h43b1cd7f598ece23881b00e3ed030688;
localparam aes_pkg::state_t pt_ecb_3 = 128'h30c81c46a35ce411e5fbc1191a0a52ef;

localparam aes_pkg::state_t ct_ecb_4 = 128'h7b0c785e27e8ad3f8223207104725dd4;
localparam aes_pkg::state_t pt_ecb_4 = 128'hf69f2445df4f9b17ad2b417be66c3710;

`endif

/* tb_aes_dec.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_aes_dec;

	`include "tb_aes_vectors.svh"

	localparam int clk_period = 20;
	localparam int rounds = int'(aes_pkg::nr);
	// key expansion, decryption and a few idle cycles per test
	localparam int num_tests = 8;
	localparam int cycles_per_test = 10 + 10 + 8;
	localparam int margin_ns = 1000;
	localparam int timeout_ns = num_tests * cycles_per_test * clk_period + margin_ns;

	logic clk;
	logic arst_n;
	logic key_load;
	aes_pkg::state_t key;
	logic start;
	aes_pkg::state_t ciphertext;
	logic key_ready;
	logic busy;
	logic done;
	aes_pkg::state_t plaintext;

	aes_dec dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.key_load(key_load),
		.key(key),
		.start(start),
		.ciphertext(ciphertext),
		.key_ready(key_ready),
		.busy(busy),
		.done(done),
		.plaintext(plaintext)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("timeout: done never arrived");
		stop_with_failure();
	end

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1);
	endtask

	// inputs change shortly after the rising edge, outputs are read there too
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_state(input string what, input aes_pkg::state_t expected,
			input aes_pkg::state_t actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected,
				actual);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, expected %b, got %b", $time, what, expected,
				actual);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("mismatch at %0t ns: %s, expected %0d, got %0d", $time, what, expected,
				actual);
			stop_with_failure();
		end
	endtask

	task automatic load_key(input aes_pkg::state_t k);
		int cycles;
		key = k;
		key_load = 1'b1;
		next_cycle();
		key_load = 1'b0;
		check_bit("key_ready right after key capture", 1'b0, key_ready);
		cycles = 0;
		while (!key_ready) begin
			next_cycle();
			cycles++;
			if (cycles > 2 * rounds) begin
				$display("key_ready never rose after key_load");
				stop_with_failure();
			end
		end
		check_count("cycles of key expansion", rounds, cycles);
	endtask

	task automatic launch_block(input aes_pkg::state_t ct);
		ciphertext = ct;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_bit("busy after start", 1'b1, busy);
	endtask

	// waits for done, then checks the result and that it holds
	task automatic finish_block(input aes_pkg::state_t pt, input int cycles_so_far);
		int cycles;
		cycles = cycles_so_far;
		while (!done) begin
			next_cycle();
			cycles++;
			if (cycles > 2 * rounds) begin
				$display("done never arrived after start");
				stop_with_failure();
			end
		end
		check_count("cycles from start to done", rounds, cycles);
		check_bit("busy with done", 1'b0, busy);
		check_state("plaintext at done", pt, plaintext);
		next_cycle();
		check_bit("done one cycle later", 1'b0, done);
		check_state("plaintext after done", pt, plaintext);
	endtask

	task automatic decrypt_block(input aes_pkg::state_t ct, input aes_pkg::state_t pt);
		launch_block(ct);
		finish_block(pt, 0);
	endtask

	task automatic expect_no_done(input int n);
		repeat (n) begin
			next_cycle();
			check_bit("done while none expected", 1'b0, done);
		end
	endtask

	task automatic test_reset_levels();
		check_bit("key_ready after reset", 1'b0, key_ready);
		check_bit("busy after reset", 1'b0, busy);
		check_bit("done after reset", 1'b0, done);
	endtask

	task automatic test_start_without_key();
		ciphertext = ct_fips_c1;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_bit("busy after start without key", 1'b0, busy);
		expect_no_done(12);
	endtask

	task automatic test_fips_c1();
		load_key(key_fips_c1);
		decrypt_block(ct_fips_c1, pt_fips_c1);
	endtask

	task automatic test_fips_b();
		load_key(key_fips_b);
		decrypt_block(ct_fips_b, pt_fips_b);
	endtask

	task automatic test_back_to_back();
		decrypt_block(ct_ecb_1, pt_ecb_1);
		launch_block(ct_ecb_2);
		repeat (4) begin
			next_cycle();
			check_state("plaintext held during next block", pt_ecb_1, plaintext);
		end
		finish_block(pt_ecb_2, 4);
	endtask

	task automatic test_start_while_busy();
		launch_block(ct_ecb_3);
		repeat (2) next_cycle();
		// both strobes land while the block is in flight
		ciphertext = ct_ecb_4;
		start = 1'b1;
		key = key_fips_c1;
		key_load = 1'b1;
		next_cycle();
		start = 1'b0;
		key_load = 1'b0;
		finish_block(pt_ecb_3, 3);
		check_bit("key_ready after ignored key_load", 1'b1, key_ready);
		expect_no_done(12);
		// old key must still be in place
		decrypt_block(ct_ecb_4, pt_ecb_4);
	endtask

	initial begin
		arst_n = 1'b0;
		key_load = 1'b0;
		key = '0;
		start = 1'b0;
		ciphertext = '0;
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;

		test_reset_levels();
		test_start_without_key();
		test_fips_c1();
		test_fips_b();
		test_back_to_back();
		test_start_while_busy();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* aes_dec.sv */
`timescale 1ns/1ns
`default_nettype none

module aes_dec (
	input  logic clk,
	input  logic arst_n,
	input  logic key_load,
	input  aes_pkg::state_t key,
	input  logic start,
	input  aes_pkg::state_t ciphertext,
	output logic key_ready,
	output logic busy,
	output logic done,
	output aes_pkg::state_t plaintext
);

	aes_pkg::state_t key_step_in;
	aes_pkg::round_t key_step_rnd;
	logic key_step_inverse;
	aes_pkg::state_t key_step_out;

	aes_round_if round_if ();

	aes_dec_iter iter_i (
		.clk(clk),
		.arst_n(arst_n),
		.key_load(key_load),
		.key(key),
		.start(start),
		.ciphertext(ciphertext),
		.key_ready(key_ready),
		.busy(busy),
		.done(done),
		.plaintext(plaintext),
		.rif(round_if.seq),
		.key_step_in(key_step_in),
		.key_step_rnd(key_step_rnd),
		.key_step_inverse(key_step_inverse),
		.key_step_out(key_step_out)
	);

	aes_inv_round round_i (
		.rif(round_if.rnd)
	);

	aes_key_sched key_sched_i (
		.key_in(key_step_in),
		.rnd(key_step_rnd),
		.inverse(key_step_inverse),
		.key_out(key_step_out)
	);

endmodule

`default_nettype wire

/* aes_dec_iter.sv */
`timescale 1ns/1ns
`default_nettype none

module aes_dec_iter (
	input  logic clk,
	input  logic arst_n,
	input  logic key_load,
	input  aes_pkg::state_t key,
	input  logic start,
	input  aes_pkg::state_t ciphertext,
	output logic key_ready,
	output logic busy,
	output logic done,
	output aes_pkg::state_t plaintext,
	aes_round_if.seq rif,
	output aes_pkg::state_t key_step_in,
	output aes_pkg::round_t key_step_rnd,
	output logic key_step_inverse,
	input  aes_pkg::state_t key_step_out
);

	typedef enum logic [1:0] {
		idle,
		expanding,
		decrypting
	} mode_t;

	mode_t mode_q;
	aes_pkg::round_t round_q;
	aes_pkg::state_t state_q;
	aes_pkg::state_t key_q;
	aes_pkg::state_t last_key_q;

	logic take_key;
	logic take_block;
	logic expand_last;
	logic last_round;

	assign busy = (mode_q == decrypting);
	// key_load wins over a start on the same edge
	assign take_key = key_load && !busy;
	assign take_block = start && key_ready && !busy && !take_key;

	// counts up while expanding, down while decrypting
	assign expand_last = (round_q == aes_pkg::round_t'(aes_pkg::nr));
	assign last_round = (round_q == aes_pkg::round_t'(1));

	assign key_step_in = key_q;
	assign key_step_rnd = round_q;
	assign key_step_inverse = busy;

	assign rif.state_in = state_q;
	assign rif.round_key = key_step_out;
	assign rif.last = last_round;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode_q <= idle;
			round_q <= '0;
			key_ready <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (take_key) begin
				mode_q <= expanding;
				round_q <= aes_pkg::round_t'(1);
				key_ready <= 1'b0;
			end else if (take_block) begin
				mode_q <= decrypting;
				round_q <= aes_pkg::round_t'(aes_pkg::nr);
			end else if (mode_q == expanding) begin
				if (expand_last) begin
					mode_q <= idle;
					key_ready <= 1'b1;
				end else begin
					round_q <= round_q + aes_pkg::round_t'(1);
				end
			end else if (mode_q == decrypting) begin
				if (last_round) begin
					mode_q <= idle;
					done <= 1'b1;
				end else begin
					round_q <= round_q - aes_pkg::round_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_key) begin
			key_q <= key;
		end else if (take_block) begin
			// initial add round key with round key 10
			key_q <= last_key_q;
			state_q <= ciphertext ^ last_key_q;
		end else if (mode_q == expanding) begin
			key_q <= key_step_out;
			if (expand_last)
				last_key_q <= key_step_out;
		end else if (mode_q == decrypting) begin
			key_q <= key_step_out;
			state_q <= rif.state_out;
			if (last_round)
				plaintext <= rif.state_out;
		end
	end

endmodule

`default_nettype wire

/* aes_key_sched.sv */
`timescale 1ns/1ns
`default_nettype none

module aes_key_sched (
	input  aes_pkg::state_t key_in,
	input  aes_pkg::round_t rnd,
	input  logic inverse,
	output aes_pkg::state_t key_out
);

	aes_pkg::word_t w0, w1, w2, w3;
	aes_pkg::word_t prev_w3;
	aes_pkg::word_t sub_in;
	aes_pkg::word_t rot;
	aes_pkg::word_t sub_out;
	aes_pkg::word_t t;

	assign w0 = key_in[127:96];
	assign w1 = key_in[95:64];
	assign w2 = key_in[63:32];
	assign w3 = key_in[31:0];

	// last word of the previous round key
	assign prev_w3 = w3 ^ w2;

	assign sub_in = inverse ? prev_w3 : w3;
	assign rot = {sub_in[23:0], sub_in[31:24]};

	genvar j;
	generate
		for (j = 0; j < 4; j++) begin : g_sbox
			aes_sbox #(
				.inverse(1'b0)
			) sbox_i (
				.x(rot[31 - 8 * j -: 8]),
				.y(sub_out[31 - 8 * j -: 8])
			);
		end
	endgenerate

	assign t = sub_out ^ {aes_pkg::rcon(rnd), 24'h000000};

	always_comb begin
		aes_pkg::word_t n0;
		aes_pkg::word_t n1;
		aes_pkg::word_t n2;
		n0 = w0 ^ t;
		n1 = w1 ^ n0;
		n2 = w2 ^ n1;
		if (inverse) begin
			key_out = {n0, w1 ^ w0, w2 ^ w1, prev_w3};
		end else begin
			key_out = {n0, n1, n2, w3 ^ n2};
		end
	end

endmodule

`default_nettype wire

/* aes_inv_round.sv */
`timescale 1ns/1ns
`default_nettype none

module aes_inv_round (
	aes_round_if.rnd rif
);

	aes_pkg::state_t shifted;
	aes_pkg::state_t subbed;
	aes_pkg::state_t keyed;
	aes_pkg::state_t mixed;

	// row r rotates right by r columns
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				shifted[127 - 8 * (r + 4 * c) -: 8] =
					rif.state_in[127 - 8 * (r + 4 * ((c - r + 4) % 4)) -: 8];
			end
		end
	end

	genvar i;
	generate
		for (i = 0; i < 16; i++) begin : g_sbox
			aes_sbox #(
				.inverse(1'b1)
			) sbox_i (
				.x(shifted[127 - 8 * i -: 8]),
				.y(subbed[127 - 8 * i -: 8])
			);
		end
	endgenerate

	assign keyed = subbed ^ rif.round_key;

	// inverse mix columns, one column at a time
	always_comb begin
		aes_pkg::byte_t a0;
		aes_pkg::byte_t a1;
		aes_pkg::byte_t a2;
		aes_pkg::byte_t a3;
		for (int c = 0; c < 4; c++) begin
			a0 = keyed[127 - 32 * c -: 8];
			a1 = keyed[119 - 32 * c -: 8];
			a2 = keyed[111 - 32 * c -: 8];
			a3 = keyed[103 - 32 * c -: 8];
			mixed[127 - 32 * c -: 8] = aes_pkg::gf_mul(a0, 8'h0e)
				^ aes_pkg::gf_mul(a1, 8'h0b)
				^ aes_pkg::gf_mul(a2, 8'h0d)
				^ aes_pkg::gf_mul(a3, 8'h09);
			mixed[119 - 32 * c -: 8] = aes_pkg::gf_mul(a0, 8'h09)
				^ aes_pkg::gf_mul(a1, 8'h0e)
				^ aes_pkg::gf_mul(a2, 8'h0b)
				^ aes_pkg::gf_mul(a3, 8'h0d);
			mixed[111 - 32 * c -: 8] = aes_pkg::gf_mul(a0, 8'h0d)
				^ aes_pkg::gf_mul(a1, 8'h09)
				^ aes_pkg::gf_mul(a2, 8'h0e)
				^ aes_pkg::gf_mul(a3, 8'h0b);
			mixed[103 - 32 * c -: 8] = aes_pkg::gf_mul(a0, 8'h0b)
				^ aes_pkg::gf_mul(a1, 8'h0d)
				^ aes_pkg::gf_mul(a2, 8'h09)
				^ aes_pkg::gf_mul(a3, 8'h0e);
		end
	end

	assign rif.state_out = rif.last ? keyed : mixed;

endmodule

`default_nettype wire

/* aes_sbox.sv */
`timescale 1ns/1ns
`default_nettype none

module aes_sbox #(
	parameter bit inverse = 1'b0
) (
	input  aes_pkg::byte_t x,
	output aes_pkg::byte_t y
);

	function automatic aes_pkg::byte_t rotl(input aes_pkg::byte_t a, input int unsigned k);
		return (a << k) | (a >> (8 - k));
	endfunction

	// a^254 is the inverse, and 0 stays 0
	function automatic aes_pkg::byte_t gf_inv(input aes_pkg::byte_t a);
		aes_pkg::byte_t sq;
		aes_pkg::byte_t acc;
		sq = aes_pkg::gf_mul(a, a);
		acc = sq;
		// multiply in a^4 through a^128
		for (int i = 0; i < 6; i++) begin
			sq = aes_pkg::gf_mul(sq, sq);
			acc = aes_pkg::gf_mul(acc, sq);
		end
		return acc;
	endfunction

	function automatic aes_pkg::byte_t affine(input aes_pkg::byte_t a);
		return a ^ rotl(a, 1) ^ rotl(a, 2) ^ rotl(a, 3) ^ rotl(a, 4) ^ 8'h63;
	endfunction

	function automatic aes_pkg::byte_t inv_affine(input aes_pkg::byte_t a);
		return rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05;
	endfunction

	generate
		if (inverse) begin : g_inv
			// undo the affine map first, then invert
			assign y = gf_inv(inv_affine(x));
		end else begin : g_fwd
			assign y = affine(gf_inv(x));
		end
	endgenerate

endmodule

`default_nettype wire

/* aes_round_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface aes_round_if;

	aes_pkg::state_t state_in;
	aes_pkg::state_t round_key;
	// no mix columns on this round
	logic last;
	aes_pkg::state_t state_out;

	modport seq (
		output state_in,
		output round_key,
		output last,
		input  state_out
	);

	modport rnd (
		input  state_in,
		input  round_key,
		input  last,
		output state_out
	);

endinterface

`default_nettype wire

/* aes_pkg.sv */
`default_nettype none

package aes_pkg;

	// byte 0 of the block sits in the top bits, columns follow each other
	typedef logic [127:0] state_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;

	localparam int unsigned nr = 10;

	typedef logic [$clog2(nr + 1) - 1:0] round_t;

	// round constant for rounds 1 to nr
	function automatic byte_t rcon(input round_t r);
		case (r)
			4'd1: rcon = 8'h01;
			4'd2: rcon = 8'h02;
			4'd3: rcon = 8'h04;
			4'd4: rcon = 8'h08;
			4'd5: rcon = 8'h10;
			4'd6: rcon = 8'h20;
			4'd7: rcon = 8'h40;
			4'd8: rcon = 8'h80;
			4'd9: rcon = 8'h1b;
			4'd10: rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	endfunction

	// product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t p;
		byte_t aa;
		p = 8'h00;
		aa = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ aa;
			aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

endpackage

`default_nettype wire
